// ==== vlog.f ====
+incdir+hdl
hdl/debug_pkg.sv
hdl/word_assembler.sv
hdl/word_queue.sv
hdl/debug_controller.sv
hdl/bucket_sender.sv
hdl/debug_unit.sv
verification/debug_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the debug unit testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module debug_unit_tb \
  -o debug_unit_sim > build.log 2>&1 \
  || { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/debug_unit_sim > sim.log 2>&1 || echo "simulation ended with an error"

grep -q "^=== PASS ===$" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed, see sim.log"; exit 1; }

// ==== verification/debug_unit_tb.sv ====
`timescale 1ns/1ps
`include "debug_macros.svh"

module debug_unit_tb;

  localparam int CYCLE_LIMIT = 4000;  // twice the longest sequence

  logic                   clk;
  logic                   reset;
  logic                   halt;
  debug_pkg::bucket_t     bucket;
  logic                   rx_done_tick;
  debug_pkg::byte_t       rx_data;
  logic                   tx_done_tick;
  debug_pkg::imem_write_t imem_write;
  logic                   ctrl_clk_mips;
  logic                   debug;
  logic                   tx_start;
  debug_pkg::byte_t       data_out;

  debug_pkg::imem_write_t exp_writes[$];  // writes still to come
  debug_pkg::byte_t       exp_bytes[$];   // report bytes still to come
  integer                 seed;
  int                     cycle_count = 0;
  int                     mips_cycles;    // processor model cycle count
  int                     halt_at;        // model halts at this count
  int                     exp_cycles;     // count implied by stimulus
  logic                   halt_rose;
  logic                   tx_busy;

  debug_unit debug_unit_inst (
    .clk           (clk),
    .reset         (reset),
    .halt          (halt),
    .bucket        (bucket),
    .rx_done_tick  (rx_done_tick),
    .rx_data       (rx_data),
    .tx_done_tick  (tx_done_tick),
    .imem_write    (imem_write),
    .ctrl_clk_mips (ctrl_clk_mips),
    .debug         (debug),
    .tx_start      (tx_start),
    .data_out      (data_out)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // reference model and compare tasks
  //////////////////////////////////////////////////

  // status word the processor model shows after a number of cycles
  function automatic debug_pkg::bucket_t bucket_of(input int cycles);
    return {8'hc3, 8'(cycles * 7), 16'(cycles)};
  endfunction

  function automatic debug_pkg::imem_write_t expected_write(input int idx,
                                                            input debug_pkg::word_t w);
    return '{en: 1'b1, addr: debug_pkg::addr_t'(idx), data: w};
  endfunction

  function automatic void expect_report(input debug_pkg::bucket_t b);
    int i;
    for (i = 0; i < `DBG_BUCKET_BYTES; i++)
      exp_bytes.push_back(b[i * `DBG_BYTE_W +: `DBG_BYTE_W]);  // byte 0 first
  endfunction

  task automatic stop_on_failure();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_failure(input string what);
    $display("%0t %s", $time, what);
    stop_on_failure();
  endtask

  task automatic check_write(input debug_pkg::imem_write_t exp,
                             input debug_pkg::imem_write_t act);
    if (act !== exp)
    begin
      $display("ERR %0t imem_write expected en=%b addr=%h data=%h actual en=%b addr=%h data=%h",
               $time, exp.en, exp.addr, exp.data, act.en, act.addr, act.data);
      stop_on_failure();
    end
  endtask

  task automatic check_byte(input string name, input debug_pkg::byte_t exp,
                            input debug_pkg::byte_t act);
    if (act !== exp)
    begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
      stop_on_failure();
    end
  endtask

  //////////////////////////////////////////////////
  // processor model, write checks, transmitter
  //////////////////////////////////////////////////

  always @(negedge clk)
  begin
    if (!reset)
    begin
      if (halt_rose)
        check_bit("ctrl_clk_mips", 1'b0, ctrl_clk_mips);  // low after halt cycle
      if (imem_write.en)
      begin
        if (exp_writes.size() == 0)
          report_failure("instruction memory written with no write expected");
        else
          check_write(exp_writes.pop_front(), imem_write);
      end
    end
    if (ctrl_clk_mips === 1'b1 && !halt)
      mips_cycles = mips_cycles + 1;  // one processor cycle
    halt_rose = !halt && (mips_cycles >= halt_at);
    halt      = (mips_cycles >= halt_at);
    bucket    = bucket_of(mips_cycles);
  end

  initial
  begin
    int delay;
    tx_done_tick = 1'b0;
    tx_busy      = 1'b0;
    forever
    begin
      @(negedge clk);
      if (!reset && tx_start === 1'b1)
      begin
        tx_busy = 1'b1;
        if (exp_bytes.size() == 0)
          report_failure("transmitter started with no report byte expected");
        else
          check_byte("data_out", exp_bytes.pop_front(), data_out);
        delay = 3 + ({$random(seed)} % 4);  // 3 to 6 cycles
        repeat (delay) @(negedge clk);
        tx_done_tick = 1'b1;
        @(negedge clk);
        tx_done_tick = 1'b0;
        while (tx_start) @(negedge clk);
        tx_busy = 1'b0;
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
      report_failure("timeout, the run did not finish within the cycle limit");
  end

  //////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////

  // one byte from the uart receiver
  task automatic send_byte(input debug_pkg::byte_t b);
    rx_data      = b;
    rx_done_tick = 1'b1;
    repeat (2) @(negedge clk);
    rx_done_tick = 1'b0;
    repeat (20) @(negedge clk);
  endtask

  task automatic send_idle_byte(input debug_pkg::byte_t b);
    int i;
    fork
      send_byte(b);
      for (i = 0; i < 22; i++)
      begin
        @(negedge clk);
        check_bit("imem_write.en", 1'b0, imem_write.en);
        check_bit("tx_start", 1'b0, tx_start);
        check_bit("ctrl_clk_mips", 1'b0, ctrl_clk_mips);
        check_bit("debug", 1'b0, debug);
      end
    join
  endtask

  // the processor model takes the new limit at the next falling edge
  task automatic set_halt_limit(input int limit);
    @(posedge clk);
    halt_at = limit;
    @(negedge clk);
  endtask

  task automatic load_program(input int n_words);
    int               i;
    int               b;
    int               waited;
    debug_pkg::word_t w;
    send_byte(`DBG_CMD_START);
    check_bit("debug", 1'b1, debug);
    for (i = 0; i < n_words; i++)
    begin
      w = $random(seed);
      if (i == n_words - 1)
        w[`DBG_WORD_W-1 -: `DBG_END_OPCODE_W] = '1;  // end of program
      else if (&w[`DBG_WORD_W-1 -: `DBG_END_OPCODE_W])
        w[`DBG_WORD_W-1] = 1'b0;
      exp_writes.push_back(expected_write(i, w));
      for (b = 0; b < `DBG_WORD_W / `DBG_BYTE_W - 1; b++)
        send_byte(w[b * `DBG_BYTE_W +: `DBG_BYTE_W]);  // lsb first
      waited = 0;
      fork
        send_byte(w[`DBG_WORD_W-1 -: `DBG_BYTE_W]);
        begin
          while (imem_write.en !== 1'b1 && waited < 12)
          begin
            @(negedge clk);
            waited++;
          end
          if (imem_write.en !== 1'b1)
            report_failure("word not written within 12 cycles of its last byte");
        end
      join
      check_bit("debug", (i == n_words - 1) ? 1'b0 : 1'b1, debug);
    end
  endtask

  // report done and the controller out of its reporting state
  task automatic wait_report();
    while (exp_bytes.size() != 0 || tx_busy ||
           debug_unit_inst.debug_controller_inst.state == debug_pkg::reporting)
      @(negedge clk);
  endtask

  task automatic step_once();
    exp_cycles = exp_cycles + 1;
    expect_report(bucket_of(exp_cycles));
    fork
      send_byte(`DBG_CMD_STEP);
      begin
        while (ctrl_clk_mips !== 1'b1) @(negedge clk);
        @(negedge clk);
        check_bit("ctrl_clk_mips", 1'b0, ctrl_clk_mips);  // exactly one cycle
      end
    join
    wait_report();
  endtask

  task automatic run_continuous(input int run_len);
    int waited;
    set_halt_limit(exp_cycles + run_len);
    exp_cycles = exp_cycles + run_len;
    expect_report(bucket_of(exp_cycles));
    waited = 0;
    fork
      send_byte(`DBG_CMD_CONTINUOUS);
      begin
        while (ctrl_clk_mips !== 1'b1)
        begin
          @(negedge clk);
          waited++;
        end
        if (waited > 3)
          report_failure("ctrl_clk_mips did not rise within 3 cycles of the command");
      end
    join
    wait_report();
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial
  begin
    seed         = 21;
    reset        = 1'b1;
    rx_done_tick = 1'b0;
    rx_data      = '0;
    halt         = 1'b0;
    halt_rose    = 1'b0;
    bucket       = '0;
    mips_cycles  = 0;
    exp_cycles   = 0;
    halt_at      = 1000;
    repeat (2) @(negedge clk);
    reset = 1'b0;

    send_idle_byte(`DBG_CMD_CONTINUOUS);  // ignored in idle
    send_idle_byte(`DBG_CMD_STEP);
    send_idle_byte(8'h5a);

    load_program(5);

    send_byte(`DBG_CMD_STEP_MODE);
    step_once();
    step_once();
    set_halt_limit(exp_cycles + 1);
    step_once();  // hits halt and returns to waiting

    run_continuous(8);

    set_halt_limit(exp_cycles + 2);
    send_byte(`DBG_CMD_STEP_MODE);
    step_once();
    step_once();
    run_continuous(5);

    load_program(3);  // reload from waiting
    repeat (4) @(negedge clk);

    if (exp_writes.size() == 0 && exp_bytes.size() == 0)
    begin
      $display("=== PASS ===");
      $finish;
    end
    else
      report_failure("expected writes or report bytes never arrived");
  end

endmodule

// ==== hdl/debug_unit.sv ====
`timescale 1ns/1ps
`include "debug_macros.svh"

module debug_unit
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   halt,
  input  debug_pkg::bucket_t     bucket,
  input  logic                   rx_done_tick,
  input  debug_pkg::byte_t       rx_data,
  input  logic                   tx_done_tick,
  output debug_pkg::imem_write_t imem_write,
  output logic                   ctrl_clk_mips,
  output logic                   debug,
  output logic                   tx_start,
  output debug_pkg::byte_t       data_out
);

  // assembler to queue
  logic                  asm_req;
  logic                  asm_ack;
  debug_pkg::prog_word_t asm_word;
  // queue to controller
  logic                  q_req;
  logic                  q_ack;
  debug_pkg::prog_word_t q_word;
  // commands and reports
  logic                  cmd_valid;
  debug_pkg::byte_t      cmd;
  logic                  report_req;
  logic                  report_ack;

  word_assembler word_assembler_inst (
    .clk          (clk),
    .reset        (reset),
    .rx_done_tick (rx_done_tick),
    .rx_data      (rx_data),
    .loading      (debug),
    .word_req     (asm_req),
    .word         (asm_word),
    .word_ack     (asm_ack),
    .cmd_valid    (cmd_valid),
    .cmd          (cmd)
  );

  word_queue #(
    .payload_t (debug_pkg::prog_word_t),
    .DEPTH     (`DBG_QUEUE_DEPTH)
  ) word_queue_inst (
    .clk      (clk),
    .reset    (reset),
    .in_req   (asm_req),
    .in_data  (asm_word),
    .in_ack   (asm_ack),
    .out_req  (q_req),
    .out_data (q_word),
    .out_ack  (q_ack)
  );

  debug_controller debug_controller_inst (
    .clk           (clk),
    .reset         (reset),
    .word_req      (q_req),
    .word          (q_word),
    .word_ack      (q_ack),
    .cmd_valid     (cmd_valid),
    .cmd           (cmd),
    .halt          (halt),
    .imem_write    (imem_write),
    .ctrl_clk_mips (ctrl_clk_mips),
    .report_req    (report_req),
    .report_ack    (report_ack)
  );

  bucket_sender bucket_sender_inst (
    .clk          (clk),
    .reset        (reset),
    .bucket       (bucket),
    .report_req   (report_req),
    .report_ack   (report_ack),
    .tx_start     (tx_start),
    .data_out     (data_out),
    .tx_done_tick (tx_done_tick)
  );

endmodule

// ==== hdl/bucket_sender.sv ====
`timescale 1ns/1ps
`include "debug_macros.svh"

module bucket_sender
(
  input  logic               clk,
  input  logic               reset,
  input  debug_pkg::bucket_t bucket,
  input  logic               report_req,
  output logic               report_ack,
  output logic               tx_start,
  output debug_pkg::byte_t   data_out,
  input  logic               tx_done_tick
);

  localparam int IDX_W = $clog2(`DBG_BUCKET_BYTES);

  logic               req_prev;
  logic               tx_prev;
  logic               req_rise;
  logic               tx_rise;
  logic               busy;
  logic [IDX_W-1:0]   byte_idx;
  logic               last_byte;
  debug_pkg::bucket_t bucket_q;  // snapshot at request

  assign req_rise  = report_req && !req_prev;
  assign tx_rise   = tx_done_tick && !tx_prev;
  assign last_byte = (byte_idx == IDX_W'(`DBG_BUCKET_BYTES - 1));
  assign data_out  = bucket_q[byte_idx * `DBG_BYTE_W +: `DBG_BYTE_W];  // byte 0 first

  always_ff @(posedge clk)
  begin
    if (req_rise && !busy)
      bucket_q <= bucket;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      req_prev   <= 1'b0;
      tx_prev    <= 1'b0;
      busy       <= 1'b0;
      byte_idx   <= '0;
      tx_start   <= 1'b0;
      report_ack <= 1'b0;
    end
    else
    begin
      req_prev <= report_req;
      tx_prev  <= tx_done_tick;
      if (req_rise && !busy)
      begin
        busy     <= 1'b1;
        byte_idx <= '0;
        tx_start <= 1'b1;
      end
      else if (busy)
      begin
        if (tx_start && tx_rise)
        begin
          tx_start <= 1'b0;  // gap before next byte
          if (last_byte)
          begin
            busy       <= 1'b0;
            report_ack <= 1'b1;
          end
          else
            byte_idx <= byte_idx + 1'b1;
        end
        else if (!tx_start && !tx_done_tick)
          tx_start <= 1'b1;
      end
      else if (report_ack && !report_req)
        report_ack <= 1'b0;
    end
  end

endmodule

// ==== hdl/debug_controller.sv ====
`timescale 1ns/1ps
`include "debug_macros.svh"

module debug_controller
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   word_req,
  input  debug_pkg::prog_word_t  word,
  output logic                   word_ack,
  input  logic                   cmd_valid,
  input  debug_pkg::byte_t       cmd,
  input  logic                   halt,
  output debug_pkg::imem_write_t imem_write,
  output logic                   ctrl_clk_mips,
  output logic                   report_req,
  input  logic                   report_ack
);

  debug_pkg::ctrl_state_t state;
  logic                   accept;          // take a word this cycle
  logic                   wr_en;
  debug_pkg::addr_t       wr_addr;
  debug_pkg::word_t       wr_data;
  debug_pkg::addr_t       next_addr;
  logic                   report_busy;     // request issued for this report
  logic                   report_to_wait;  // report came from continuous run

  // words wait in the queue while the processor runs or reports
  assign accept = word_req && !word_ack &&
                  (state != debug_pkg::running) && (state != debug_pkg::reporting);

  assign imem_write = '{en: wr_en, addr: wr_addr, data: wr_data};

  //////////////////////////////////////////////////
  // program write path
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      wr_addr <= word.first ? '0 : next_addr;
      wr_data <= word.data;
    end
  end

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state          <= debug_pkg::idle;
      word_ack       <= 1'b0;
      wr_en          <= 1'b0;
      next_addr      <= '0;
      ctrl_clk_mips  <= 1'b0;
      report_req     <= 1'b0;
      report_busy    <= 1'b0;
      report_to_wait <= 1'b0;
    end
    else
    begin
      wr_en <= 1'b0;
      if (accept)
      begin
        word_ack  <= 1'b1;
        wr_en     <= 1'b1;  // single write pulse per word
        next_addr <= (word.first ? '0 : next_addr) + 1'b1;
      end
      else if (word_ack && !word_req)
        word_ack <= 1'b0;

      case (state)
        debug_pkg::waiting:
        begin
          if (cmd_valid && (cmd == `DBG_CMD_CONTINUOUS))
          begin
            ctrl_clk_mips <= 1'b1;
            state         <= debug_pkg::running;
          end
          else if (cmd_valid && (cmd == `DBG_CMD_STEP_MODE))
            state <= debug_pkg::stepping;
        end
        debug_pkg::stepping:
        begin
          if (cmd_valid && (cmd == `DBG_CMD_STEP))
          begin
            ctrl_clk_mips  <= 1'b1;  // exactly one cycle
            report_to_wait <= 1'b0;
            state          <= debug_pkg::reporting;
          end
        end
        debug_pkg::running:
        begin
          if (halt)
          begin
            ctrl_clk_mips  <= 1'b0;  // high through the halt cycle
            report_to_wait <= 1'b1;
            state          <= debug_pkg::reporting;
          end
        end
        debug_pkg::reporting:
        begin
          ctrl_clk_mips <= 1'b0;
          if (!report_busy)
          begin
            report_req  <= 1'b1;
            report_busy <= 1'b1;
          end
          else if (report_req && report_ack)
            report_req <= 1'b0;
          else if (!report_req && !report_ack)
          begin
            report_busy <= 1'b0;  // handshake back to zero
            state <= (report_to_wait || halt) ? debug_pkg::waiting : debug_pkg::stepping;
          end
        end
        default:
        begin
        end
      endcase

      // a new program takes over from idle, waiting or stepping
      if (accept)
        state <= word.last ? debug_pkg::waiting : debug_pkg::loading;
    end
  end

endmodule

// ==== hdl/word_queue.sv ====
`timescale 1ns/1ps
`include "debug_macros.svh"

module word_queue
#(
  parameter type payload_t = debug_pkg::prog_word_t,
  parameter int  DEPTH     = `DBG_QUEUE_DEPTH
)
(
  input  logic     clk,
  input  logic     reset,
  input  logic     in_req,
  input  payload_t in_data,
  output logic     in_ack,
  output logic     out_req,
  output payload_t out_data,
  input  logic     out_ack
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign full     = (count == CNT_W'(DEPTH));
  assign push     = in_req && !in_ack && !full;  // ack stays low while full
  assign pop      = out_req && out_ack;
  assign out_data = mem[rd_ptr];                  // head stays stable until pop

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

  //////////////////////////////////////////////////
  // pointers and handshakes
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      in_ack  <= 1'b0;
      out_req <= 1'b0;
    end
    else
    begin
      // input side
      if (push)
      begin
        wr_ptr <= next_ptr(wr_ptr);
        in_ack <= 1'b1;
      end
      else if (in_ack && !in_req)
        in_ack <= 1'b0;  // return to zero

      // output side
      if (pop)
      begin
        rd_ptr  <= next_ptr(rd_ptr);
        out_req <= 1'b0;
      end
      else if (!out_req && !out_ack && (count != '0))
        out_req <= 1'b1;  // offer head once ack is back low

      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

endmodule

// ==== hdl/word_assembler.sv ====
`timescale 1ns/1ps
`include "debug_macros.svh"

module word_assembler
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  rx_done_tick,
  input  debug_pkg::byte_t      rx_data,
  output logic                  loading,
  output logic                  word_req,
  output debug_pkg::prog_word_t word,
  input  logic                  word_ack,
  output logic                  cmd_valid,
  output debug_pkg::byte_t      cmd
);

  localparam int BYTES_PER_WORD = `DBG_WORD_W / `DBG_BYTE_W;
  localparam int CNT_W          = $clog2(BYTES_PER_WORD);

  logic             rx_prev;        // rx_done_tick one cycle back
  logic             rx_edge;
  logic             first_pending;  // next word opens a program
  logic [CNT_W-1:0] byte_cnt;
  debug_pkg::word_t shift_q;
  debug_pkg::word_t assembled;
  logic             take_byte;
  logic             word_done;
  logic             end_word;

  assign rx_edge   = rx_done_tick && !rx_prev;
  assign take_byte = rx_edge && loading && !word_req && !word_ack;  // dropped while held
  assign word_done = take_byte && (byte_cnt == CNT_W'(BYTES_PER_WORD - 1));
  assign assembled = {rx_data, shift_q[`DBG_WORD_W-1:`DBG_BYTE_W]};  // lsb byte first
  assign end_word  = &assembled[`DBG_WORD_W-1 -: `DBG_END_OPCODE_W];

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rx_prev       <= 1'b0;
      loading       <= 1'b0;
      first_pending <= 1'b0;
      byte_cnt      <= '0;
      word_req      <= 1'b0;
      cmd_valid     <= 1'b0;
    end
    else
    begin
      rx_prev   <= rx_done_tick;
      cmd_valid <= 1'b0;
      if (word_req && word_ack)
        word_req <= 1'b0;  // queue took it
      if (!loading)
      begin
        if (rx_edge)
        begin
          if (rx_data == `DBG_CMD_START)
          begin
            loading       <= 1'b1;
            first_pending <= 1'b1;
            byte_cnt      <= '0;
          end
          else
            cmd_valid <= 1'b1;  // pass on to controller
        end
      end
      else if (take_byte)
      begin
        byte_cnt <= byte_cnt + 1'b1;
        if (word_done)
        begin
          byte_cnt      <= '0;
          word_req      <= 1'b1;
          first_pending <= 1'b0;
          if (end_word)
            loading <= 1'b0;  // program complete
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (take_byte)
      shift_q <= assembled;
    if (word_done)
    begin
      word.first <= first_pending;
      word.last  <= end_word;
      word.data  <= assembled;
    end
    if (rx_edge && !loading)
      cmd <= rx_data;
  end

endmodule

// ==== hdl/debug_pkg.sv ====
`include "debug_macros.svh"

package debug_pkg;

  //////////////////////////////////////////////////
  // scalar types
  //////////////////////////////////////////////////

  typedef logic [`DBG_BYTE_W-1:0] byte_t;    // one uart byte
  typedef logic [`DBG_WORD_W-1:0] word_t;    // one instruction
  typedef logic [`DBG_ADDR_W-1:0] addr_t;    // imem address
  typedef logic [`DBG_WORD_W-1:0] bucket_t;  // processor status word

  //////////////////////////////////////////////////
  // bundles
  //////////////////////////////////////////////////

  // one assembled program word
  typedef struct packed {
    logic  first;  // starts a new program
    logic  last;   // end-of-program word
    word_t data;
  } prog_word_t;

  // instruction memory write port
  typedef struct packed {
    logic  en;
    addr_t addr;
    word_t data;
  } imem_write_t;

  // debug controller FSM
  typedef enum logic [2:0] {
    idle,
    loading,
    waiting,
    stepping,
    running,
    reporting
  } ctrl_state_t;

endpackage

// ==== hdl/debug_macros.svh ====
`ifndef DEBUG_MACROS_SVH
`define DEBUG_MACROS_SVH

//////////////////////////////////////////////////
// widths and sizes
//////////////////////////////////////////////////

`define DBG_BYTE_W        8   // uart byte
`define DBG_WORD_W        32  // instruction and bucket
`define DBG_ADDR_W        7   // instruction memory address
`define DBG_BUCKET_BYTES  4   // bytes per status report
`define DBG_QUEUE_DEPTH   4   // default word queue depth
`define DBG_END_OPCODE_W  6   // all-ones opcode ends a program

//////////////////////////////////////////////////
// host command bytes
//////////////////////////////////////////////////

`define DBG_CMD_START       8'h01  // begin program load
`define DBG_CMD_CONTINUOUS  8'h02  // free run until halt
`define DBG_CMD_STEP_MODE   8'h03  // enter stepping
`define DBG_CMD_STEP        8'h06  // single processor cycle

`endif
